// ==== common/cnn_bus_pkg.sv ====
package cnn_bus_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// --------------------
	// AHB-lite codes
	localparam int TRANS_W = 2;
	localparam logic [TRANS_W-1:0] TRANS_NONSEQ = 2'b10;
	localparam logic [TRANS_W-1:0] TRANS_SEQ    = 2'b11;
	localparam int RESP_W = 2;
	localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

	// --------------------
	// Register map, word index in HADDR[REG_W+1:2]
	localparam int REG_W    = 5;
	localparam int WORD_LSB = 2; // Byte offset within a word
	localparam logic [REG_W-1:0] REG_WIDTH_HEIGHT = 5'd0;
	localparam logic [REG_W-1:0] REG_DELAYS       = 5'd1;
	localparam logic [REG_W-1:0] REG_LAYER_CFG    = 5'd2;
	localparam logic [REG_W-1:0] REG_START        = 5'd3;
	localparam logic [REG_W-1:0] REG_DONE         = 5'd4;
	localparam logic [REG_W-1:0] REG_BIAS01       = 5'd5;
	localparam logic [REG_W-1:0] REG_BIAS23       = 5'd6;
	localparam logic [REG_W-1:0] REG_WEIGHT0      = 5'd8; // Nine tap words follow

	// Field positions inside the words
	localparam int HEIGHT_LSB = 16;
	localparam int BSHIFT_LSB = 8;
	localparam int ASHIFT_LSB = 13;

	localparam int IMG_SEL_BIT = 12; // Set selects image memory
endpackage

// ==== common/cnn_layer_pkg.sv ====
package cnn_layer_pkg;

	localparam int PIX_W = 8; // Grayscale pixel and activation

	// Frame geometry
	localparam int SIZE_W     = 12;
	localparam int DELAY_W    = 12;
	localparam int MAX_PIX    = 1024; // 32x32 frame
	localparam int PIX_ADDR_W = 10;

	// --------------------
	// Kernel shape and arithmetic
	localparam int N_CH     = 4;
	localparam int N_TAP    = 9;
	localparam int WT_W     = 8;  // Signed weight
	localparam int BIAS_W   = 16; // Signed bias
	localparam int ACC_W    = 24;
	localparam int BSHIFT_W = 5;
	localparam int ASHIFT_W = 3;
	localparam logic ACT_RELU = 1'b0; // act_type 1 is linear

	// Tap 0 upper left, raster order
	typedef logic [N_TAP-1:0][PIX_W-1:0] window_t;

	// Signed bytes, one row of taps per channel
	typedef logic [N_CH-1:0][N_TAP-1:0][WT_W-1:0] weights_t;

	typedef struct packed {
		logic [SIZE_W-1:0]   width;
		logic [SIZE_W-1:0]   height;
		logic [DELAY_W-1:0]  start_up;   // Idle cycles before row 0
		logic [DELAY_W-1:0]  hsync;      // Idle cycles after each row
		logic                act_type;
		logic [BSHIFT_W-1:0] bias_shift; // Left shift of bias
		logic [ASHIFT_W-1:0] act_shift;  // Right shift of sum
	} layer_cfg_t;

	// Power-up configuration, 8x8 ReLU
	localparam layer_cfg_t CFG_RESET = '{
		width:      12'd8,
		height:     12'd8,
		start_up:   12'd20,
		hsync:      12'd4,
		act_type:   1'b0,
		bias_shift: 5'd0,
		act_shift:  3'd0
	};
endpackage

// ==== common/cnn_scan_if.sv ====
`timescale 1ns/10ps

// Raster position from scanner to window buffer
interface cnn_scan_if;
	logic                                 data_run; // One pixel per cycle
	logic [cnn_layer_pkg::SIZE_W-1:0]     row;
	logic [cnn_layer_pkg::SIZE_W-1:0]     col;
	logic [cnn_layer_pkg::PIX_ADDR_W-1:0] pix_idx;  // row*width+col

	modport master (
		output data_run, row, col, pix_idx
	);

	modport slave (
		input data_run, row, col, pix_idx
	);
endinterface

// ==== rtl/cnn_ahb_regs.sv ====
`timescale 1ns/10ps

module cnn_ahb_regs (
	input  logic                                      clk,
	input  logic                                      rstn,
	input  logic                                      hsel_i,
	input  logic                                      hready_i,
	input  logic [cnn_bus_pkg::TRANS_W-1:0]           htrans_i,
	input  logic                                      hwrite_i,
	input  logic [cnn_bus_pkg::ADDR_W-1:0]            haddr_i,
	input  logic [cnn_bus_pkg::DATA_W-1:0]            hwdata_i,
	input  logic                                      frame_done_i,
	output logic                                      hready_o,
	output logic [cnn_bus_pkg::RESP_W-1:0]            hresp_o,
	output logic [cnn_bus_pkg::DATA_W-1:0]            hrdata_o,
	output cnn_layer_pkg::layer_cfg_t                 cfg_o,
	output cnn_layer_pkg::weights_t                   weights_o,
	output logic [cnn_layer_pkg::N_CH-1:0][cnn_layer_pkg::BIAS_W-1:0] bias_o,
	output logic                                      start_o,
	output logic                                      img_we_o,
	output logic [cnn_layer_pkg::PIX_ADDR_W-1:0]      img_addr_o,
	output logic [cnn_layer_pkg::PIX_W-1:0]           img_data_o
);

	logic [cnn_bus_pkg::REG_W-1:0]         q_sel;   // Latched word index
	logic                                  q_wr;    // Write in data phase
	logic                                  q_img;   // Image memory target
	logic [cnn_layer_pkg::PIX_ADDR_W-1:0]  q_pix;
	logic                                  addr_ok;
	logic                                  reg_wr;
	logic                                  is_wt;
	logic [cnn_bus_pkg::REG_W-1:0]         tap_sel;
	cnn_layer_pkg::layer_cfg_t             cfg_q;
	cnn_layer_pkg::weights_t               weights_q;
	logic [cnn_layer_pkg::N_CH-1:0][cnn_layer_pkg::BIAS_W-1:0] bias_q;
	logic                                  start_q;
	logic                                  done_q;

	// --------------------
	// Address phase
	assign addr_ok = hsel_i & hready_i &
		((htrans_i == cnn_bus_pkg::TRANS_NONSEQ) || (htrans_i == cnn_bus_pkg::TRANS_SEQ));

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			q_sel <= '0;
			q_wr  <= 1'b0;
			q_img <= 1'b0;
			q_pix <= '0;
		end else if (addr_ok) begin
			q_sel <= haddr_i[cnn_bus_pkg::WORD_LSB +: cnn_bus_pkg::REG_W];
			q_wr  <= hwrite_i;
			q_img <= haddr_i[cnn_bus_pkg::IMG_SEL_BIT];
			q_pix <= haddr_i[cnn_bus_pkg::WORD_LSB +: cnn_layer_pkg::PIX_ADDR_W];
		end else begin
			q_wr <= 1'b0; // Idle or busy transfer
		end
	end

	assign reg_wr  = q_wr & ~q_img;
	assign tap_sel = q_sel - cnn_bus_pkg::REG_WEIGHT0;
	assign is_wt   = (q_sel >= cnn_bus_pkg::REG_WEIGHT0) &&
		(q_sel < cnn_bus_pkg::REG_WEIGHT0 + cnn_layer_pkg::N_TAP);

	// --------------------
	// Data phase writes
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cfg_q   <= cnn_layer_pkg::CFG_RESET;
			start_q <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			start_q <= reg_wr && (q_sel == cnn_bus_pkg::REG_START) && hwdata_i[0];
			if (start_q)
				done_q <= 1'b0;
			else if (frame_done_i)
				done_q <= 1'b1; // Sticky until next START
			if (reg_wr) begin
				case (q_sel)
					cnn_bus_pkg::REG_WIDTH_HEIGHT: begin
						cfg_q.width  <= hwdata_i[0 +: cnn_layer_pkg::SIZE_W];
						cfg_q.height <= hwdata_i[cnn_bus_pkg::HEIGHT_LSB +: cnn_layer_pkg::SIZE_W];
					end
					cnn_bus_pkg::REG_DELAYS: begin
						cfg_q.start_up <= hwdata_i[0 +: cnn_layer_pkg::DELAY_W];
						cfg_q.hsync    <= hwdata_i[cnn_layer_pkg::DELAY_W +: cnn_layer_pkg::DELAY_W];
					end
					cnn_bus_pkg::REG_LAYER_CFG: begin
						cfg_q.act_type   <= hwdata_i[0];
						cfg_q.bias_shift <= hwdata_i[cnn_bus_pkg::BSHIFT_LSB +: cnn_layer_pkg::BSHIFT_W];
						cfg_q.act_shift  <= hwdata_i[cnn_bus_pkg::ASHIFT_LSB +: cnn_layer_pkg::ASHIFT_W];
					end
					default: ;
				endcase
			end
		end
	end

	// Kernel coefficients, written before START
	always_ff @(posedge clk) begin
		if (reg_wr && (q_sel == cnn_bus_pkg::REG_BIAS01)) begin
			bias_q[0] <= hwdata_i[0 +: cnn_layer_pkg::BIAS_W];
			bias_q[1] <= hwdata_i[cnn_layer_pkg::BIAS_W +: cnn_layer_pkg::BIAS_W];
		end
		if (reg_wr && (q_sel == cnn_bus_pkg::REG_BIAS23)) begin
			bias_q[2] <= hwdata_i[0 +: cnn_layer_pkg::BIAS_W];
			bias_q[3] <= hwdata_i[cnn_layer_pkg::BIAS_W +: cnn_layer_pkg::BIAS_W];
		end
		if (reg_wr && is_wt) begin
			for (int c = 0; c < cnn_layer_pkg::N_CH; c++)
				weights_q[c][tap_sel] <= hwdata_i[c*cnn_layer_pkg::WT_W +: cnn_layer_pkg::WT_W];
		end
	end

	// --------------------
	// Readback, zero for reserved bits
	always_comb begin
		hrdata_o = '0;
		if (!q_img) begin
			case (q_sel)
				cnn_bus_pkg::REG_WIDTH_HEIGHT: begin
					hrdata_o[0 +: cnn_layer_pkg::SIZE_W] = cfg_q.width;
					hrdata_o[cnn_bus_pkg::HEIGHT_LSB +: cnn_layer_pkg::SIZE_W] = cfg_q.height;
				end
				cnn_bus_pkg::REG_DELAYS: begin
					hrdata_o[0 +: cnn_layer_pkg::DELAY_W] = cfg_q.start_up;
					hrdata_o[cnn_layer_pkg::DELAY_W +: cnn_layer_pkg::DELAY_W] = cfg_q.hsync;
				end
				cnn_bus_pkg::REG_LAYER_CFG: begin
					hrdata_o[0] = cfg_q.act_type;
					hrdata_o[cnn_bus_pkg::BSHIFT_LSB +: cnn_layer_pkg::BSHIFT_W] = cfg_q.bias_shift;
					hrdata_o[cnn_bus_pkg::ASHIFT_LSB +: cnn_layer_pkg::ASHIFT_W] = cfg_q.act_shift;
				end
				cnn_bus_pkg::REG_DONE:   hrdata_o[0] = done_q;
				cnn_bus_pkg::REG_BIAS01: hrdata_o = {bias_q[1], bias_q[0]};
				cnn_bus_pkg::REG_BIAS23: hrdata_o = {bias_q[3], bias_q[2]};
				default: begin
					if (is_wt) begin
						for (int c = 0; c < cnn_layer_pkg::N_CH; c++)
							hrdata_o[c*cnn_layer_pkg::WT_W +: cnn_layer_pkg::WT_W] =
								weights_q[c][tap_sel];
					end
				end
			endcase
		end
	end

	assign hready_o   = 1'b1; // Zero wait states
	assign hresp_o    = cnn_bus_pkg::RESP_OKAY;
	assign cfg_o      = cfg_q;
	assign weights_o  = weights_q;
	assign bias_o     = bias_q;
	assign start_o    = start_q;
	assign img_we_o   = q_wr & q_img;
	assign img_addr_o = q_pix;
	assign img_data_o = hwdata_i[cnn_layer_pkg::PIX_W-1:0]; // Low byte only
endmodule

// ==== rtl/cnn_scan_ctrl.sv ====
`timescale 1ns/10ps

module cnn_scan_ctrl (
	input  logic                      clk,
	input  logic                      rstn,
	input  cnn_layer_pkg::layer_cfg_t cfg_i,
	input  logic                      start_i,
	cnn_scan_if.master                scan
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_STARTUP,
		S_ROW,
		S_HSYNC
	} state_t;

	state_t                               state_q;
	logic [cnn_layer_pkg::DELAY_W-1:0]    dly_cnt;  // Shared by start-up and hsync
	logic [cnn_layer_pkg::SIZE_W-1:0]     row_q;
	logic [cnn_layer_pkg::SIZE_W-1:0]     col_q;
	logic [cnn_layer_pkg::PIX_ADDR_W-1:0] pix_q;
	logic                                 last_col;
	logic                                 last_row;

	assign last_col = (col_q == cfg_i.width - 1'b1);
	assign last_row = (row_q == cfg_i.height - 1'b1);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= S_IDLE;
			dly_cnt <= '0;
			row_q   <= '0;
			col_q   <= '0;
			pix_q   <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (start_i) begin // Only seen here, busy ignores it
						row_q   <= '0;
						col_q   <= '0;
						pix_q   <= '0;
						dly_cnt <= 1;
						state_q <= (cfg_i.start_up == '0) ? S_ROW : S_STARTUP;
					end
				end
				S_STARTUP: begin
					if (dly_cnt == cfg_i.start_up)
						state_q <= S_ROW;
					else
						dly_cnt <= dly_cnt + 1'b1;
				end
				S_ROW: begin
					pix_q <= pix_q + 1'b1;
					if (last_col) begin
						col_q <= '0;
						if (last_row) begin
							state_q <= S_IDLE; // Frame complete
						end else begin
							row_q   <= row_q + 1'b1;
							dly_cnt <= 1;
							state_q <= (cfg_i.hsync == '0) ? S_ROW : S_HSYNC;
						end
					end else begin
						col_q <= col_q + 1'b1;
					end
				end
				S_HSYNC: begin
					if (dly_cnt == cfg_i.hsync)
						state_q <= S_ROW;
					else
						dly_cnt <= dly_cnt + 1'b1;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	assign scan.data_run = (state_q == S_ROW);
	assign scan.row      = row_q;
	assign scan.col      = col_q;
	assign scan.pix_idx  = pix_q;
endmodule

// ==== rtl/cnn_window_buf.sv ====
`timescale 1ns/10ps

module cnn_window_buf (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  cnn_layer_pkg::layer_cfg_t            cfg_i,
	input  logic                                 img_we_i,
	input  logic [cnn_layer_pkg::PIX_ADDR_W-1:0] img_addr_i,
	input  logic [cnn_layer_pkg::PIX_W-1:0]      img_data_i,
	cnn_scan_if.slave                            scan,
	output logic                                 win_valid_o,
	output cnn_layer_pkg::window_t               win_o
);

	logic [cnn_layer_pkg::PIX_W-1:0]      img_mem [cnn_layer_pkg::MAX_PIX];
	logic [cnn_layer_pkg::PIX_ADDR_W-1:0] stride;  // One row in pixels
	logic                                 first_row;
	logic                                 last_row;
	logic                                 first_col;
	logic                                 last_col;
	cnn_layer_pkg::window_t               win_next;

	// Host writes the frame over AHB
	always_ff @(posedge clk) begin
		if (img_we_i)
			img_mem[img_addr_i] <= img_data_i;
	end

	// --------------------
	// Edge flags for zero padding
	assign first_row = (scan.row == '0);
	assign last_row  = (scan.row == cfg_i.height - 1'b1);
	assign first_col = (scan.col == '0);
	assign last_col  = (scan.col == cfg_i.width - 1'b1);
	assign stride    = cfg_i.width[cnn_layer_pkg::PIX_ADDR_W-1:0];

	always_comb begin
		logic [cnn_layer_pkg::PIX_ADDR_W-1:0] addr;
		logic                                 pad;
		for (int t = 0; t < cnn_layer_pkg::N_TAP; t++) begin
			addr = scan.pix_idx + cnn_layer_pkg::PIX_ADDR_W'(t % 3) - 1'b1; // Column -1..+1
			if (t < 3)
				addr = addr - stride; // Row above
			else if (t >= 6)
				addr = addr + stride; // Row below
			pad = ((t < 3) && first_row) || ((t >= 6) && last_row) ||
				((t % 3 == 0) && first_col) || ((t % 3 == 2) && last_col);
			win_next[t] = pad ? '0 : img_mem[addr];
		end
	end

	// One cycle from data_run to win_valid
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			win_valid_o <= 1'b0;
		else
			win_valid_o <= scan.data_run;
	end

	always_ff @(posedge clk) begin
		if (scan.data_run)
			win_o <= win_next;
	end
endmodule

// ==== conv/cnn_conv_array.sv ====
`timescale 1ns/10ps

module cnn_conv_array (
	input  logic                                             clk,
	input  logic                                             rstn,
	input  cnn_layer_pkg::layer_cfg_t                        cfg_i,
	input  cnn_layer_pkg::weights_t                          weights_i,
	input  logic [cnn_layer_pkg::N_CH-1:0][cnn_layer_pkg::BIAS_W-1:0] bias_i,
	input  logic                                             win_valid_i,
	input  cnn_layer_pkg::window_t                           win_i,
	output logic [cnn_layer_pkg::N_CH*cnn_layer_pkg::PIX_W-1:0] out_pixel_o,
	output logic                                             out_valid_o,
	output logic                                             frame_done_o
);

	logic                                valid_s1;
	logic                                valid_s2;
	logic                                done_q;
	logic [2*cnn_layer_pkg::SIZE_W-1:0]  frame_pix;
	logic [2*cnn_layer_pkg::SIZE_W-1:0]  out_cnt;

	// --------------------
	// Kernels, one per output channel
	for (genvar c = 0; c < cnn_layer_pkg::N_CH; c++) begin : g_ch
		logic signed [cnn_layer_pkg::ACC_W-1:0] prod_q [cnn_layer_pkg::N_TAP];
		logic signed [cnn_layer_pkg::ACC_W-1:0] bias_ext;
		logic signed [cnn_layer_pkg::ACC_W-1:0] sum;
		logic signed [cnn_layer_pkg::ACC_W-1:0] shifted;
		logic [cnn_layer_pkg::PIX_W-1:0]        act;
		logic [cnn_layer_pkg::PIX_W-1:0]        act_q;

		// Stage 1, signed weight times unsigned pixel
		always_ff @(posedge clk) begin
			if (win_valid_i) begin
				for (int t = 0; t < cnn_layer_pkg::N_TAP; t++)
					prod_q[t] <= $signed(weights_i[c][t]) * $signed({1'b0, win_i[t]});
			end
		end

		assign bias_ext = $signed(bias_i[c]); // Sign extend to ACC_W

		// Stage 2, sum, shift and activation
		always_comb begin
			sum = bias_ext <<< cfg_i.bias_shift;
			for (int t = 0; t < cnn_layer_pkg::N_TAP; t++)
				sum = sum + prod_q[t];
			shifted = sum >>> cfg_i.act_shift;
			if (cfg_i.act_type == cnn_layer_pkg::ACT_RELU) begin
				if (shifted < 0)
					act = '0;
				else if (shifted > 255)
					act = 8'hff; // Clamp to full scale
				else
					act = shifted[cnn_layer_pkg::PIX_W-1:0];
			end else begin
				if (shifted > 127)
					act = 8'h7f;
				else if (shifted < -128)
					act = 8'h80;
				else
					act = shifted[cnn_layer_pkg::PIX_W-1:0]; // Two's complement byte
			end
		end

		always_ff @(posedge clk) begin
			if (valid_s1)
				act_q <= act;
		end

		assign out_pixel_o[c*cnn_layer_pkg::PIX_W +: cnn_layer_pkg::PIX_W] = act_q;
	end

	// --------------------
	// Valid pipe and frame counter
	assign frame_pix = cfg_i.width * cfg_i.height;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			done_q   <= 1'b0;
			out_cnt  <= '0;
		end else begin
			valid_s1 <= win_valid_i;
			valid_s2 <= valid_s1;
			done_q   <= 1'b0;
			if (valid_s1) begin
				if (out_cnt == frame_pix - 1'b1) begin
					out_cnt <= '0;
					done_q  <= 1'b1; // Lines up with last valid
				end else begin
					out_cnt <= out_cnt + 1'b1;
				end
			end
		end
	end

	assign out_valid_o  = valid_s2;
	assign frame_done_o = done_q;
endmodule

// ==== rtl/cnn_accel_top.sv ====
`timescale 1ns/10ps

module cnn_accel_top (
	input  logic                                             clk,
	input  logic                                             rstn,
	input  logic                                             hsel_i,
	input  logic                                             hready_i,
	input  logic [cnn_bus_pkg::TRANS_W-1:0]                  htrans_i,
	input  logic                                             hwrite_i,
	input  logic [cnn_bus_pkg::ADDR_W-1:0]                   haddr_i,
	input  logic [cnn_bus_pkg::DATA_W-1:0]                   hwdata_i,
	output logic                                             hready_o,
	output logic [cnn_bus_pkg::RESP_W-1:0]                   hresp_o,
	output logic [cnn_bus_pkg::DATA_W-1:0]                   hrdata_o,
	output logic [cnn_layer_pkg::N_CH*cnn_layer_pkg::PIX_W-1:0] out_pixel_o,
	output logic                                             out_valid_o
);

	cnn_layer_pkg::layer_cfg_t            cfg;
	cnn_layer_pkg::weights_t              weights;
	logic [cnn_layer_pkg::N_CH-1:0][cnn_layer_pkg::BIAS_W-1:0] bias;
	logic                                 start;
	logic                                 frame_done;
	logic                                 img_we;
	logic [cnn_layer_pkg::PIX_ADDR_W-1:0] img_addr;
	logic [cnn_layer_pkg::PIX_W-1:0]      img_data;
	logic                                 win_valid;
	cnn_layer_pkg::window_t               win;

	cnn_scan_if u_scan_if ();

	// --------------------
	// Host side
	cnn_ahb_regs u_regs (
		.clk          (clk),
		.rstn         (rstn),
		.hsel_i       (hsel_i),
		.hready_i     (hready_i),
		.htrans_i     (htrans_i),
		.hwrite_i     (hwrite_i),
		.haddr_i      (haddr_i),
		.hwdata_i     (hwdata_i),
		.frame_done_i (frame_done),
		.hready_o     (hready_o),
		.hresp_o      (hresp_o),
		.hrdata_o     (hrdata_o),
		.cfg_o        (cfg),
		.weights_o    (weights),
		.bias_o       (bias),
		.start_o      (start),
		.img_we_o     (img_we),
		.img_addr_o   (img_addr),
		.img_data_o   (img_data)
	);

	// --------------------
	// Pixel pipeline, three cycles data_run to out_valid
	cnn_scan_ctrl u_scan (
		.clk     (clk),
		.rstn    (rstn),
		.cfg_i   (cfg),
		.start_i (start),
		.scan    (u_scan_if.master)
	);

	cnn_window_buf u_win (
		.clk         (clk),
		.rstn        (rstn),
		.cfg_i       (cfg),
		.img_we_i    (img_we),
		.img_addr_i  (img_addr),
		.img_data_i  (img_data),
		.scan        (u_scan_if.slave),
		.win_valid_o (win_valid),
		.win_o       (win)
	);

	cnn_conv_array u_conv (
		.clk          (clk),
		.rstn         (rstn),
		.cfg_i        (cfg),
		.weights_i    (weights),
		.bias_i       (bias),
		.win_valid_i  (win_valid),
		.win_i        (win),
		.out_pixel_o  (out_pixel_o),
		.out_valid_o  (out_valid_o),
		.frame_done_o (frame_done)
	);
endmodule

// ==== test/tb_cnn_model.svh ====
`ifndef TB_CNN_MODEL_SVH
`define TB_CNN_MODEL_SVH

// --------------------
// Stimulus source, 16-bit Fibonacci LFSR
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16,14,13,11
endfunction

// One step per bit taken, MSB first
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v = {v[30:0], lfsr_q[0]};
	end
	return v;
endfunction

// --------------------
// Reference 3x3 conv, zero padded, all four channels
function automatic logic [31:0] ref_pixel(input int r, input int c);
	logic [31:0] word;
	int sum;
	int sh;
	int act;
	int rr;
	int cc;
	int pix;
	word = '0;
	for (int ch = 0; ch < cnn_layer_pkg::N_CH; ch++) begin
		sum = bias_v[ch] <<< m_bshift;
		for (int t = 0; t < cnn_layer_pkg::N_TAP; t++) begin
			rr = r + t / 3 - 1;
			cc = c + t % 3 - 1;
			pix = 0; // Outside the frame
			if (rr >= 0 && rr < m_h && cc >= 0 && cc < m_w)
				pix = int'(img[rr * m_w + cc]);
			sum = sum + wts[ch][t] * pix;
		end
		sh = sum >>> m_ashift;
		if (m_act == 0)
			act = (sh < 0) ? 0 : ((sh > 255) ? 255 : sh); // ReLU clamp
		else
			act = (sh > 127) ? 127 : ((sh < -128) ? -128 : sh);
		word[ch*8 +: 8] = act[7:0];
	end
	return word;
endfunction

// Whole frame in raster order
function automatic void expect_frame();
	for (int r = 0; r < m_h; r++)
		for (int c = 0; c < m_w; c++)
			exp_q.push_back(ref_pixel(r, c));
endfunction

// Register word of two biases, lower channel low
function automatic logic [31:0] bias_word(input int lo);
	return {bias_v[lo+1][15:0], bias_v[lo][15:0]};
endfunction

`endif

// ==== test/tb_cnn_accel.sv ====
`timescale 1ns/10ps

module tb_cnn_accel;

	localparam int START_UP   = 12;
	localparam int HSYNC      = 3;
	localparam int FRAME_RELU = START_UP + 8 * (8 + HSYNC);
	localparam int FRAME_LIN  = START_UP + 7 * (5 + HSYNC);
	// Two 8x8 frames, two 5x7 frames and one idle watch, plus bus traffic
	localparam int CYCLE_LIMIT = 2 * FRAME_RELU + 3 * FRAME_LIN + 1500;

	logic        clk;
	logic        rstn;
	logic        hsel;
	logic        hready_in;
	logic [1:0]  htrans;
	logic        hwrite;
	logic [31:0] haddr;
	logic [31:0] hwdata;
	logic        hready_out;
	logic [1:0]  hresp;
	logic [31:0] hrdata;
	logic [31:0] out_pixel;
	logic        out_valid;

	// Model state
	logic [7:0]  img [cnn_layer_pkg::MAX_PIX];
	int          wts [cnn_layer_pkg::N_CH][cnn_layer_pkg::N_TAP];
	int          bias_v [cnn_layer_pkg::N_CH];
	int          m_w;
	int          m_h;
	int          m_act;
	int          m_bshift;
	int          m_ashift;
	logic [15:0] lfsr_q;
	logic [31:0] exp_q [$]; // Pixels still to come
	logic [31:0] mon_exp;
	string       cur_test = "reset";
	int          errors = 0;
	int          checks = 0;
	int          valid_cnt = 0;
	int          cycles = 0;

	`include "tb_cnn_model.svh"

	cnn_accel_top dut (
		.clk         (clk),
		.rstn        (rstn),
		.hsel_i      (hsel),
		.hready_i    (hready_in),
		.htrans_i    (htrans),
		.hwrite_i    (hwrite),
		.haddr_i     (haddr),
		.hwdata_i    (hwdata),
		.hready_o    (hready_out),
		.hresp_o     (hresp),
		.hrdata_o    (hrdata),
		.out_pixel_o (out_pixel),
		.out_valid_o (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout, run still busy after %0d cycles in %s", CYCLE_LIMIT, cur_test);
			$display("** FAIL **");
			$finish;
		end
	end

	// --------------------
	// Checks
	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input int err0);
		$display("test %-18s %0d errors", cur_test, errors - err0);
	endtask

	// Outputs sampled on the falling edge
	always @(negedge clk) begin
		if (rstn) begin
			assert (hready_out === 1'b1 && hresp === cnn_bus_pkg::RESP_OKAY)
			else begin
				$display("%s: bus stalled or answered with an error response", cur_test);
				errors++;
			end
			if (out_valid === 1'b1) begin
				valid_cnt++;
				assert (exp_q.size() > 0)
				else begin
					$display("%s: out_valid_o pulse beyond the expected frame", cur_test);
					errors++;
				end
				if (exp_q.size() > 0) begin
					mon_exp = exp_q.pop_front();
					check_word("pixel", mon_exp, out_pixel);
				end
			end
		end
	end

	// --------------------
	// AHB master with one transfer at a time
	function automatic logic [31:0] reg_addr(input logic [cnn_bus_pkg::REG_W-1:0] idx);
		return 32'(idx) << cnn_bus_pkg::WORD_LSB;
	endfunction

	task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		hsel   <= 1'b1;
		htrans <= cnn_bus_pkg::TRANS_NONSEQ;
		hwrite <= 1'b1;
		haddr  <= addr;
		@(posedge clk);
		hsel   <= 1'b0;
		htrans <= 2'b00; // IDLE
		hwrite <= 1'b0;
		hwdata <= data;  // Data phase
	endtask

	task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk);
		hsel   <= 1'b1;
		htrans <= cnn_bus_pkg::TRANS_NONSEQ;
		hwrite <= 1'b0;
		haddr  <= addr;
		@(posedge clk);
		hsel   <= 1'b0;
		htrans <= 2'b00;
		@(negedge clk);
		data = hrdata;
	endtask

	// Poll DONE until the frame ends
	task automatic wait_done();
		logic [31:0] d;
		d = '0;
		while (d[0] !== 1'b1)
			ahb_read(reg_addr(cnn_bus_pkg::REG_DONE), d);
	endtask

	task automatic start_frame();
		ahb_write(reg_addr(cnn_bus_pkg::REG_START), 32'd1);
	endtask

	// --------------------
	// Layer setup
	task automatic load_image();
		logic [31:0] tmp;
		logic [31:0] addr;
		for (int i = 0; i < m_w * m_h; i++) begin
			tmp = rand_bits(8);
			img[i] = tmp[7:0];
			addr = (32'd1 << cnn_bus_pkg::IMG_SEL_BIT) | (32'(i) << cnn_bus_pkg::WORD_LSB);
			ahb_write(addr, {24'h0, tmp[7:0]});
		end
	endtask

	task automatic write_weights();
		logic [31:0] word;
		logic [31:0] tmp;
		for (int t = 0; t < cnn_layer_pkg::N_TAP; t++) begin
			for (int c = 0; c < cnn_layer_pkg::N_CH; c++) begin
				tmp = rand_bits(8);
				wts[c][t] = int'($signed(tmp[7:0]));
				word[c*8 +: 8] = tmp[7:0]; // Channel c at byte c
			end
			ahb_write(reg_addr(cnn_bus_pkg::REG_WEIGHT0 + 5'(t)), word);
		end
	endtask

	task automatic write_biases();
		ahb_write(reg_addr(cnn_bus_pkg::REG_BIAS01), bias_word(0));
		ahb_write(reg_addr(cnn_bus_pkg::REG_BIAS23), bias_word(2));
	endtask

	// --------------------
	// Test sequence
	initial begin
		logic [31:0] rd;
		logic [31:0] tmp;
		int          err0;
		lfsr_q = 16'd81;
		rstn      <= 1'b0;
		hsel      <= 1'b0;
		hready_in <= 1'b1;
		htrans    <= 2'b00;
		hwrite    <= 1'b0;
		haddr     <= '0;
		hwdata    <= '0;
		repeat (4) @(posedge clk);
		rstn <= 1'b1;

		// Reset values, then readback with reserved bits set
		cur_test = "readback";
		err0 = errors;
		ahb_read(reg_addr(cnn_bus_pkg::REG_WIDTH_HEIGHT), rd);
		check_word("reset size", 32'h0008_0008, rd);
		ahb_read(reg_addr(cnn_bus_pkg::REG_DELAYS), rd);
		check_word("reset delays", 32'h0000_4014, rd); // 20 and 4
		ahb_read(reg_addr(cnn_bus_pkg::REG_DONE), rd);
		check_word("reset done", 32'h0, rd);
		ahb_write(reg_addr(cnn_bus_pkg::REG_WIDTH_HEIGHT), 32'hF00A_F006); // 6 wide, 10 high
		ahb_read(reg_addr(cnn_bus_pkg::REG_WIDTH_HEIGHT), rd);
		check_word("size", 32'h000A_0006, rd);
		ahb_write(reg_addr(cnn_bus_pkg::REG_DELAYS), 32'hFF00_0000 | (HSYNC << 12) | START_UP);
		ahb_read(reg_addr(cnn_bus_pkg::REG_DELAYS), rd);
		check_word("delays", (HSYNC << 12) | START_UP, rd);
		ahb_write(reg_addr(cnn_bus_pkg::REG_LAYER_CFG), 32'hFFFF_E0FE); // ReLU, act_shift 7
		ahb_read(reg_addr(cnn_bus_pkg::REG_LAYER_CFG), rd);
		check_word("layer cfg", 32'h0000_E000, rd);
		for (int c = 0; c < cnn_layer_pkg::N_CH; c++) begin
			tmp = rand_bits(16);
			bias_v[c] = int'($signed(tmp[15:0]));
		end
		write_biases();
		ahb_read(reg_addr(cnn_bus_pkg::REG_BIAS01), rd);
		check_word("bias01", bias_word(0), rd);
		ahb_read(reg_addr(cnn_bus_pkg::REG_BIAS23), rd);
		check_word("bias23", bias_word(2), rd);
		ahb_read(reg_addr(5'd7), rd); // Unmapped
		check_word("unmapped", 32'h0, rd);
		report_test(err0);

		cur_test = "relu_8x8";
		err0 = errors;
		m_w = 8;
		m_h = 8;
		m_act = 0;
		m_bshift = 0;
		m_ashift = 7;
		ahb_write(reg_addr(cnn_bus_pkg::REG_WIDTH_HEIGHT), {4'h0, 12'd8, 4'h0, 12'd8});
		write_weights();
		load_image();
		expect_frame();
		valid_cnt = 0;
		start_frame();
		wait_done();
		report_test(err0);

		// Count and DONE, then the same frame again
		cur_test = "frame_done";
		err0 = errors;
		check_word("valid count", 32'd64, valid_cnt);
		check_word("outputs left", 32'd0, 32'(exp_q.size()));
		ahb_read(reg_addr(cnn_bus_pkg::REG_DONE), rd);
		check_word("done after frame", 32'h1, rd);
		expect_frame();
		valid_cnt = 0;
		start_frame();
		ahb_read(reg_addr(cnn_bus_pkg::REG_DONE), rd);
		check_word("done after start", 32'h0, rd);
		wait_done();
		check_word("second count", 32'd64, valid_cnt);
		report_test(err0);

		// Negative bias, bias_shift 4, act_shift 7
		cur_test = "linear_5x7";
		err0 = errors;
		m_w = 5;
		m_h = 7;
		m_act = 1;
		m_bshift = 4;
		m_ashift = 7;
		ahb_write(reg_addr(cnn_bus_pkg::REG_WIDTH_HEIGHT), {4'h0, 12'd7, 4'h0, 12'd5});
		ahb_write(reg_addr(cnn_bus_pkg::REG_LAYER_CFG), 32'h0000_E401);
		for (int c = 0; c < cnn_layer_pkg::N_CH; c++) begin
			tmp = rand_bits(10);
			bias_v[c] = -int'(tmp) - 1000;
		end
		write_biases();
		load_image();
		expect_frame();
		valid_cnt = 0;
		start_frame();
		wait_done();
		check_word("valid count", 32'd35, valid_cnt);
		report_test(err0);

		// Second START lands mid-frame
		cur_test = "start_while_busy";
		err0 = errors;
		expect_frame();
		valid_cnt = 0;
		start_frame();
		wait (valid_cnt > 0);
		start_frame();
		wait_done();
		repeat (FRAME_LIN) @(posedge clk); // Room for a stray second frame
		check_word("valid count", 32'd35, valid_cnt);
		check_word("outputs left", 32'd0, 32'(exp_q.size()));
		report_test(err0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end
endmodule

// ==== cnn_accel.f ====
+incdir+test
common/cnn_bus_pkg.sv
common/cnn_layer_pkg.sv
common/cnn_scan_if.sv
rtl/cnn_ahb_regs.sv
rtl/cnn_scan_ctrl.sv
rtl/cnn_window_buf.sv
conv/cnn_conv_array.sv
rtl/cnn_accel_top.sv
test/tb_cnn_accel.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_cnn_accel

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

$(SIM): cnn_accel.f $(wildcard common/*.sv rtl/*.sv conv/*.sv test/*.sv test/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn_accel -f cnn_accel.f

clean:
	rm -rf obj_dir
